// File: design/id_pkg.sv
// Shared definitions of the RV32I decode stage
// Widths, major opcodes, control enums, instruction format views and port structs

package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  // PC step for the JAL link value, no compressed instructions
  localparam logic [XLEN-1:0] INSN_BYTES = 32'd4;

  // Major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_JAL    = 7'h6f;

  //////////////////////////////////////////////////////////////////////
  // Control enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    // Compares, result goes to branch_decision
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  typedef enum logic [1:0] {LSU_WORD, LSU_HALF, LSU_BYTE} lsu_type_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction word, one view per format
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_r_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_i_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } fmt_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } fmt_b_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } fmt_u_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_j_t;

  typedef union packed {
    fmt_r_t r;
    fmt_i_t i;
    fmt_s_t s;
    fmt_b_t b;
    fmt_u_t u;
    fmt_j_t j;
  } insn_u;

  //////////////////////////////////////////////////////////////////////
  // Port structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic       is_lsu;
    logic       is_branch;
    logic       is_jump;
    logic       illegal;
    logic       rf_we;
    // Memory access attributes
    logic       lsu_we;
    lsu_type_e  lsu_size;
    logic       lsu_sign_ext;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    alu_op_e    alu_op;
  } dec_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] i;
    logic [XLEN-1:0] s;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] u;
    logic [XLEN-1:0] j;
  } imm_set_t;

  typedef struct packed {
    alu_op_e         alu_op;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
  } ex_req_t;

  typedef struct packed {
    logic            req;
    logic            we;
    lsu_type_e       size;
    logic            sign_ext;
    logic [XLEN-1:0] wdata;
  } lsu_req_t;

  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

// File: design/id_decoder.sv
// Instruction decoder of the decode stage
// Opcode and funct decode into controls, illegal detection, immediate build

`timescale 1ns/1ns

module id_decoder import id_pkg::*; (
  input  insn_u                 instr_i,
  input  logic                  first_cycle_i,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output dec_ctrl_t             ctrl_o,
  output imm_set_t              imm_o
);

  // Register fields sit at the same place in every format
  assign rf_raddr_a_o = instr_i.r.rs1;
  assign rf_raddr_b_o = instr_i.r.rs2;
  assign rf_waddr_o   = instr_i.r.rd;

  //////////////////////////////////////////////////////////////////////
  // Immediates, all sign extended
  //////////////////////////////////////////////////////////////////////

  assign imm_o.i = {{20{instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};
  assign imm_o.s = {{20{instr_i.s.imm11_5[6]}}, instr_i.s.imm11_5, instr_i.s.imm4_0};
  assign imm_o.b = {{19{instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
  assign imm_o.u = {instr_i.u.imm31_12, 12'b0};
  assign imm_o.j = {{11{instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};

  //////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.lsu_size  = LSU_WORD;
    ctrl_o.op_a_sel  = OP_A_REG_A;
    ctrl_o.op_b_sel  = OP_B_REG_B;
    ctrl_o.imm_b_sel = IMM_B_I;
    ctrl_o.alu_op    = ALU_ADD;

    case (instr_i.r.opcode)
      OPC_OP: begin
        ctrl_o.rf_we = 1'b1;
        // Only add/sub and srl/sra have a second funct7 encoding
        if (instr_i.r.funct7 == 7'h20) begin
          ctrl_o.illegal = !(instr_i.r.funct3 inside {3'b000, 3'b101});
        end else begin
          ctrl_o.illegal = (instr_i.r.funct7 != 7'h00);
        end
        case (instr_i.r.funct3)
          3'b000:  ctrl_o.alu_op = instr_i.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl_o.alu_op = ALU_SLL;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b011:  ctrl_o.alu_op = ALU_SLTU;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b101:  ctrl_o.alu_op = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          default: ctrl_o.alu_op = ALU_AND;
        endcase
      end

      OPC_OP_IMM: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        case (instr_i.i.funct3)
          3'b000:  ctrl_o.alu_op = ALU_ADD;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b011:  ctrl_o.alu_op = ALU_SLTU;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          3'b111:  ctrl_o.alu_op = ALU_AND;
          3'b001: begin
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = (instr_i.r.funct7 != 7'h00);
          end
          default: begin
            // Shift right, bit 30 picks arithmetic
            ctrl_o.alu_op  = instr_i.r.funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = !(instr_i.r.funct7 inside {7'h00, 7'h20});
          end
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = instr_i.u.opcode[5] ? OP_A_ZERO : OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        ctrl_o.imm_b_sel = IMM_B_U;
      end

      OPC_LOAD, OPC_STORE: begin
        // Address is rs1 plus I or S immediate
        ctrl_o.is_lsu       = 1'b1;
        ctrl_o.lsu_we       = instr_i.s.opcode[5];
        ctrl_o.rf_we        = ~instr_i.s.opcode[5];
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.imm_b_sel    = instr_i.s.opcode[5] ? IMM_B_S : IMM_B_I;
        ctrl_o.lsu_sign_ext = ~instr_i.i.funct3[2];
        case (instr_i.i.funct3[1:0])
          2'b00:   ctrl_o.lsu_size = LSU_BYTE;
          2'b01:   ctrl_o.lsu_size = LSU_HALF;
          default: ctrl_o.lsu_size = LSU_WORD;
        endcase
        // Stores have no unsigned forms, word access has no unsigned form
        ctrl_o.illegal = (instr_i.i.funct3[1:0] == 2'b11) ||
                         (instr_i.i.funct3[2] && (instr_i.s.opcode[5] ||
                                                  instr_i.i.funct3[1]));
      end

      OPC_BRANCH: begin
        ctrl_o.is_branch = 1'b1;
        ctrl_o.imm_b_sel = IMM_B_B;
        if (first_cycle_i) begin
          // Cycle one compares rs1 against rs2
          case (instr_i.b.funct3)
            3'b000:  ctrl_o.alu_op = ALU_EQ;
            3'b001:  ctrl_o.alu_op = ALU_NE;
            3'b100:  ctrl_o.alu_op = ALU_LT;
            3'b101:  ctrl_o.alu_op = ALU_GE;
            3'b110:  ctrl_o.alu_op = ALU_LTU;
            3'b111:  ctrl_o.alu_op = ALU_GEU;
            default: ctrl_o.illegal = 1'b1;
          endcase
        end else begin
          // Cycle two adds pc and B immediate for the target
          ctrl_o.op_a_sel = OP_A_CURRPC;
          ctrl_o.op_b_sel = OP_B_IMM;
        end
      end

      OPC_JAL: begin
        ctrl_o.is_jump   = 1'b1;
        ctrl_o.rf_we     = 1'b1;
        ctrl_o.op_a_sel  = OP_A_CURRPC;
        ctrl_o.op_b_sel  = OP_B_IMM;
        // Target first, link value second
        ctrl_o.imm_b_sel = first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // An illegal word must not touch memory, PC or registers
    if (ctrl_o.illegal) begin
      ctrl_o.is_lsu    = 1'b0;
      ctrl_o.is_branch = 1'b0;
      ctrl_o.is_jump   = 1'b0;
      ctrl_o.rf_we     = 1'b0;
    end
  end

endmodule

// File: design/id_sequencer.sv
// Decode stage sequencer
// First/multi cycle FSM, stalls, PC redirect and instruction done

`timescale 1ns/1ns

module id_sequencer import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  input  logic      branch_decision_i,
  input  logic      lsu_resp_valid_i,
  output logic      first_cycle_o,
  output logic      executing_o,
  output logic      pc_set_o,
  output logic      instr_done_o,
  output logic      id_in_ready_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e id_fsm_q, id_fsm_d;
  logic    branch_set_d, branch_set_q;
  logic    jump_set;
  logic    stall_mem, stall_branch, stall_jump, stall_id;
  logic    multicycle_done;

  // ALU is single cycle, any valid instruction executes
  assign executing_o   = instr_valid_i;
  assign first_cycle_o = instr_valid_i & (id_fsm_q == FIRST_CYCLE);

  // Memory op always stalls its first cycle, then until the response
  assign stall_mem = instr_valid_i & ctrl_i.is_lsu & (~lsu_resp_valid_i | first_cycle_o);

  // Only memory ops wait in the second state
  assign multicycle_done = ctrl_i.is_lsu ? lsu_resp_valid_i : 1'b1;

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    id_fsm_d     = id_fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set     = 1'b0;

    if (executing_o) begin
      case (id_fsm_q)
        FIRST_CYCLE: begin
          if (ctrl_i.is_lsu) begin
            id_fsm_d = MULTI_CYCLE;
          end else if (ctrl_i.is_branch) begin
            // Taken path needs the target add in cycle two
            id_fsm_d     = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (ctrl_i.is_jump) begin
            // Redirect now, link write next cycle
            id_fsm_d   = MULTI_CYCLE;
            stall_jump = 1'b1;
            jump_set   = 1'b1;
          end
        end
        default: begin
          if (multicycle_done) begin
            id_fsm_d = FIRST_CYCLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_fsm_q <= FIRST_CYCLE;
    end else if (executing_o) begin
      id_fsm_q <= id_fsm_d;
    end
  end

  // Taken branch redirects one cycle after the compare
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign pc_set_o = branch_set_q | jump_set;

  assign stall_id      = stall_mem | stall_branch | stall_jump;
  assign instr_done_o  = executing_o & ~stall_id;
  // Free for a new word whenever nothing holds the stage
  assign id_in_ready_o = ~stall_id;

endmodule

// File: design/id_ex_drive.sv
// Decode stage output side
// ALU operand muxes, LSU request and register file write port

`timescale 1ns/1ns

module id_ex_drive import id_pkg::*; (
  input  dec_ctrl_t             ctrl_i,
  input  imm_set_t              imm_i,
  input  logic                  executing_i,
  input  logic                  first_cycle_i,
  input  logic                  done_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic [XLEN-1:0]       result_i,
  input  logic [REG_ADDR_W-1:0] rf_waddr_i,
  output ex_req_t               ex_req_o,
  output lsu_req_t              lsu_req_o,
  output rf_wr_t                rf_wr_o
);

  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] imm_b;

  //////////////////////////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_REG_A:  operand_a = rf_rdata_a_i;
      OP_A_CURRPC: operand_a = pc_i;
      default:     operand_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.imm_b_sel)
      IMM_B_I: imm_b = imm_i.i;
      IMM_B_S: imm_b = imm_i.s;
      IMM_B_B: imm_b = imm_i.b;
      IMM_B_U: imm_b = imm_i.u;
      IMM_B_J: imm_b = imm_i.j;
      // Link value step
      default: imm_b = INSN_BYTES;
    endcase
  end

  assign ex_req_o.alu_op    = ctrl_i.alu_op;
  assign ex_req_o.operand_a = operand_a;
  assign ex_req_o.operand_b = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : rf_rdata_b_i;

  //////////////////////////////////////////////////////////////////////
  // LSU request
  //////////////////////////////////////////////////////////////////////

  // One request per access, in its first cycle
  assign lsu_req_o.req      = executing_i & first_cycle_i & ctrl_i.is_lsu;
  assign lsu_req_o.we       = ctrl_i.lsu_we;
  assign lsu_req_o.size     = ctrl_i.lsu_size;
  assign lsu_req_o.sign_ext = ctrl_i.lsu_sign_ext;
  // Store data straight from rs2
  assign lsu_req_o.wdata    = rf_rdata_b_i;

  //////////////////////////////////////////////////////////////////////
  // Register write
  //////////////////////////////////////////////////////////////////////

  // Write lands in the done cycle, ALU result or load data alike
  assign rf_wr_o.we    = done_i & ctrl_i.rf_we & ~ctrl_i.illegal;
  assign rf_wr_o.waddr = rf_waddr_i;
  assign rf_wr_o.wdata = result_i;

endmodule

// File: design/id_stage.sv
// Top of the RV32I decode stage
// Decoder, sequencer and EX drive wired together, illegal flag output

`timescale 1ns/1ns

module id_stage import id_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Fetch side
  input  logic                  instr_valid_i,
  input  insn_u                 instr_i,
  input  logic [XLEN-1:0]       pc_i,
  // Register file read
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  // EX and LSU returns
  input  logic                  branch_decision_i,
  input  logic                  lsu_resp_valid_i,
  input  logic [XLEN-1:0]       result_i,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output ex_req_t               ex_req_o,
  output lsu_req_t              lsu_req_o,
  output rf_wr_t                rf_wr_o,
  // Control towards fetch
  output logic                  pc_set_o,
  output logic                  instr_done_o,
  output logic                  id_in_ready_o,
  output logic                  illegal_insn_o
);

  dec_ctrl_t             dec_ctrl;
  imm_set_t              dec_imm;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic                  first_cycle;
  logic                  executing;

  id_decoder i_id_decoder (
    .instr_i      (instr_i),
    .first_cycle_i(first_cycle),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .rf_waddr_o   (rf_waddr),
    .ctrl_o       (dec_ctrl),
    .imm_o        (dec_imm)
  );

  id_sequencer i_id_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_valid_i    (instr_valid_i),
    .ctrl_i           (dec_ctrl),
    .branch_decision_i(branch_decision_i),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .first_cycle_o    (first_cycle),
    .executing_o      (executing),
    .pc_set_o         (pc_set_o),
    .instr_done_o     (instr_done_o),
    .id_in_ready_o    (id_in_ready_o)
  );

  id_ex_drive i_id_ex_drive (
    .ctrl_i       (dec_ctrl),
    .imm_i        (dec_imm),
    .executing_i  (executing),
    .first_cycle_i(first_cycle),
    .done_i       (instr_done_o),
    .pc_i         (pc_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .result_i     (result_i),
    .rf_waddr_i   (rf_waddr),
    .ex_req_o     (ex_req_o),
    .lsu_req_o    (lsu_req_o),
    .rf_wr_o      (rf_wr_o)
  );

  // Flag only a word that fetch marks valid
  assign illegal_insn_o = instr_valid_i & dec_ctrl.illegal;

endmodule

// File: tb/id_stage_checker.sv
// Timing rule assertions for the decode stage
// Bound into id_stage

`timescale 1ns/1ns

module id_stage_checker import id_pkg::*; (
  input logic     clk_i,
  input logic     rst_ni,
  input lsu_req_t lsu_req_o,
  input logic     pc_set_o,
  input logic     instr_done_o,
  input rf_wr_t   rf_wr_o,
  input logic     illegal_insn_o
);

  // One LSU request per access
  a_lsu_req_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o.req |=> !lsu_req_o.req)
    else $error("LSU request held high for two cycles");

  // One redirect per branch or jump
  a_pc_set_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_set_o |=> !pc_set_o)
    else $error("PC set held high for two cycles");

  a_write_in_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rf_wr_o.we |-> instr_done_o)
    else $error("Register write outside the done cycle");

  // Illegal word has no side effects
  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    illegal_insn_o |-> (!lsu_req_o.req && !pc_set_o))
    else $error("Illegal instruction issued a request or redirect");

endmodule

bind id_stage id_stage_checker i_id_stage_checker (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .lsu_req_o     (lsu_req_o),
  .pc_set_o      (pc_set_o),
  .instr_done_o  (instr_done_o),
  .rf_wr_o       (rf_wr_o),
  .illegal_insn_o(illegal_insn_o)
);

// File: tb/tb_id_stage.sv
// Testbench of the decode stage
// Clock, reset, golden file stimulus, compare task, timeout and verdict

`timescale 1ns/1ns

module tb_id_stage import id_pkg::*; ();

  localparam int NUM_VECS   = 32;
  localparam int NUM_FIELDS = 19;
  localparam int TIMEOUT    = NUM_VECS * 8 + 20;

  // Golden file columns
  localparam int F_INSTR = 0;
  localparam int F_PC    = 1;
  localparam int F_RS1   = 2;
  localparam int F_RS2   = 3;
  localparam int F_BR    = 4;
  localparam int F_DLY   = 5;
  localparam int F_RES   = 6;
  localparam int F_ALU   = 7;
  localparam int F_OPA   = 8;
  localparam int F_OPB   = 9;
  localparam int F_REQ   = 10;
  localparam int F_WE    = 11;
  localparam int F_SIZE  = 12;
  localparam int F_SEXT  = 13;
  localparam int F_RFWE  = 14;
  localparam int F_WADDR = 15;
  localparam int F_WDATA = 16;
  localparam int F_PCSET = 17;
  localparam int F_ILL   = 18;

  logic            clk_i;
  logic            rst_ni;
  logic            instr_valid_i;
  insn_u           instr_i;
  logic [XLEN-1:0] pc_i;
  logic [XLEN-1:0] rf_rdata_a_i;
  logic [XLEN-1:0] rf_rdata_b_i;
  logic            branch_decision_i;
  logic            lsu_resp_valid_i;
  logic [XLEN-1:0] result_i;
  logic [REG_ADDR_W-1:0] rf_raddr_a_o;
  logic [REG_ADDR_W-1:0] rf_raddr_b_o;
  ex_req_t         ex_req_o;
  lsu_req_t        lsu_req_o;
  rf_wr_t          rf_wr_o;
  logic            pc_set_o;
  logic            instr_done_o;
  logic            id_in_ready_o;
  logic            illegal_insn_o;

  logic [31:0] golden_mem [0:NUM_VECS*NUM_FIELDS-1];
  logic [31:0] vec [0:NUM_FIELDS-1];
  int          cycle_cnt;
  integer      seed;

  id_stage i_id_stage (.*);

  always #20 clk_i = ~clk_i;

  // Run limit in cycles
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the instruction sequence did not complete in time");
      $display("Testbench failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("Testbench failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // B-type immediate per the RV32I encoding
  function automatic logic [31:0] branch_offset(input logic [31:0] word);
    branch_offset = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  endfunction

  task automatic check_idle();
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    check_value("lsu_req_o.req", 32'(lsu_req_o.req), 32'h0);
    check_value("rf_wr_o.we", 32'(rf_wr_o.we), 32'h0);
    check_value("instr_done_o", 32'(instr_done_o), 32'h0);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'h0);
    // Nothing holds the stage without a valid word
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
  endtask

  // Done and ready move together while an instruction is held
  task automatic check_done(input logic expected);
    check_value("instr_done_o", 32'(instr_done_o), 32'(expected));
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'(expected));
  endtask

  task automatic check_rf_write();
    check_value("rf_wr_o.we", 32'(rf_wr_o.we), vec[F_RFWE]);
    if (vec[F_RFWE] != 0) begin
      check_value("rf_wr_o.waddr", 32'(rf_wr_o.waddr), vec[F_WADDR]);
      check_value("rf_wr_o.wdata", rf_wr_o.wdata, vec[F_WDATA]);
    end
  endtask

  // Everything fixed by the first cycle of any instruction
  task automatic check_first_cycle();
    // Register fields of the RV32I encoding
    check_value("rf_raddr_a_o", 32'(rf_raddr_a_o), 32'(vec[F_INSTR][19:15]));
    check_value("rf_raddr_b_o", 32'(rf_raddr_b_o), 32'(vec[F_INSTR][24:20]));
    check_value("ex_req_o.alu_op", 32'(ex_req_o.alu_op), vec[F_ALU]);
    check_value("ex_req_o.operand_a", ex_req_o.operand_a, vec[F_OPA]);
    check_value("ex_req_o.operand_b", ex_req_o.operand_b, vec[F_OPB]);
    check_value("illegal_insn_o", 32'(illegal_insn_o), vec[F_ILL]);
    check_value("lsu_req_o.req", 32'(lsu_req_o.req), vec[F_REQ]);
    if (vec[F_REQ] != 0) begin
      check_value("lsu_req_o.we", 32'(lsu_req_o.we), vec[F_WE]);
      check_value("lsu_req_o.size", 32'(lsu_req_o.size), vec[F_SIZE]);
      check_value("lsu_req_o.sign_ext", 32'(lsu_req_o.sign_ext), vec[F_SEXT]);
      check_value("lsu_req_o.wdata", lsu_req_o.wdata, vec[F_RS2]);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // Drive one golden line and follow it to its done cycle
  task automatic run_vector(input int idx);
    logic [6:0] opcode;
    int         lsu_delay;
    for (int f = 0; f < NUM_FIELDS; f++) begin
      vec[f] = golden_mem[idx*NUM_FIELDS + f];
    end
    opcode = vec[F_INSTR][6:0];
    @(posedge clk_i);
    instr_valid_i     <= 1'b1;
    instr_i           <= vec[F_INSTR];
    pc_i              <= vec[F_PC];
    rf_rdata_a_i      <= vec[F_RS1];
    rf_rdata_b_i      <= vec[F_RS2];
    branch_decision_i <= vec[F_BR][0];
    result_i          <= vec[F_RES];
    lsu_resp_valid_i  <= 1'b0;
    @(negedge clk_i);
    check_first_cycle();
    if (vec[F_ILL] == 0 && (opcode == OPC_LOAD || opcode == OPC_STORE)) begin
      check_done(1'b0);
      check_value("rf_wr_o.we", 32'(rf_wr_o.we), 32'h0);
      lsu_delay = int'(vec[F_DLY]);
      if (lsu_delay == 0) begin
        lsu_delay = 1 + int'($unsigned($random(seed)) % 4);
      end
      for (int k = 1; k < lsu_delay; k++) begin
        next_cycle();
        check_value("lsu_req_o.req", 32'(lsu_req_o.req), 32'h0);
        check_done(1'b0);
      end
      @(posedge clk_i);
      lsu_resp_valid_i <= 1'b1;
      @(negedge clk_i);
      check_value("lsu_req_o.req", 32'(lsu_req_o.req), 32'h0);
      check_done(1'b1);
      check_rf_write();
    end else if (vec[F_ILL] == 0 && opcode == OPC_BRANCH && vec[F_BR] != 0) begin
      check_done(1'b0);
      check_value("pc_set_o", 32'(pc_set_o), 32'h0);
      next_cycle();
      // Target add in cycle two
      check_value("ex_req_o.alu_op", 32'(ex_req_o.alu_op), 32'(ALU_ADD));
      check_value("ex_req_o.operand_a", ex_req_o.operand_a, vec[F_PC]);
      check_value("ex_req_o.operand_b", ex_req_o.operand_b, branch_offset(vec[F_INSTR]));
      check_value("pc_set_o", 32'(pc_set_o), vec[F_PCSET]);
      check_done(1'b1);
      check_value("rf_wr_o.we", 32'(rf_wr_o.we), 32'h0);
    end else if (vec[F_ILL] == 0 && opcode == OPC_JAL) begin
      check_value("pc_set_o", 32'(pc_set_o), vec[F_PCSET]);
      check_done(1'b0);
      check_value("rf_wr_o.we", 32'(rf_wr_o.we), 32'h0);
      next_cycle();
      // Link value pc + 4
      check_value("ex_req_o.alu_op", 32'(ex_req_o.alu_op), 32'(ALU_ADD));
      check_value("ex_req_o.operand_a", ex_req_o.operand_a, vec[F_PC]);
      check_value("ex_req_o.operand_b", ex_req_o.operand_b, INSN_BYTES);
      check_value("pc_set_o", 32'(pc_set_o), 32'h0);
      check_done(1'b1);
      check_rf_write();
    end else begin
      check_value("pc_set_o", 32'(pc_set_o), vec[F_PCSET]);
      check_done(1'b1);
      check_rf_write();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_i           = '0;
    pc_i              = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    result_i          = '0;
    cycle_cnt         = 0;
    seed              = 32'h1cb9;
    $readmemh("tb/id_golden.txt", golden_mem);

    // Controls stay low through reset and the idle cycles after it
    for (int c = 0; c < 3; c++) begin
      @(negedge clk_i);
      check_idle();
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int c = 0; c < 2; c++) begin
      @(negedge clk_i);
      check_idle();
    end

    for (int v = 0; v < NUM_VECS; v++) begin
      run_vector(v);
    end

    @(posedge clk_i);
    instr_valid_i    <= 1'b0;
    lsu_resp_valid_i <= 1'b0;
    @(negedge clk_i);
    check_idle();

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: src.f
design/id_pkg.sv
design/id_decoder.sv
design/id_sequencer.sv
design/id_ex_drive.sv
design/id_stage.sv
tb/id_stage_checker.sv
tb/tb_id_stage.sv

// File: run.sh
#!/bin/sh
# Build the decode stage testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_id_stage -f src.f -o sim_id_stage \
  && ./obj_dir/sim_id_stage \
  || exit 1

// File: tb/id_golden.txt
// instr pc rs1 rs2 br dly result | alu opa opb req we size sext rfwe waddr wdata pcset ill
// dly 0 picks a random LSU delay, size 0 word 1 half 2 byte
00510093 100 7 0 0 0 c 0 7 5 0 0 0 0 1 1 c 0 0
002081b3 104 c 7 0 0 13 0 c 7 0 0 0 0 1 3 13 0 0
40118233 108 13 c 0 0 7 1 13 c 0 0 0 0 1 4 7 0 0
0020c2b3 10c aa 55 0 0 ff 2 aa 55 0 0 0 0 1 5 ff 0 0
0020e333 110 f0 f 0 0 ff 3 f0 f 0 0 0 0 1 6 ff 0 0
0020f3b3 114 ff f 0 0 f 4 ff f 0 0 0 0 1 7 f 0 0
00209433 118 1 4 0 0 10 5 1 4 0 0 0 0 1 8 10 0 0
4020d4b3 11c 80000000 4 0 0 f8000000 7 80000000 4 0 0 0 0 1 9 f8000000 0 0
0020b533 120 1 2 0 0 1 9 1 2 0 0 0 0 1 a 1 0 0
0030d593 124 f0 0 0 0 1e 6 f0 3 0 0 0 0 1 b 1e 0 0
4020d613 128 fffffff0 0 0 0 fffffffc 7 fffffff0 402 0 0 0 0 1 c fffffffc 0 0
fff0a693 12c 5 0 0 0 0 8 5 ffffffff 0 0 0 0 1 d 0 0 0
12345737 130 99 0 0 0 12345000 0 0 12345000 0 0 0 0 1 e 12345000 0 0
fffff797 134 0 0 0 0 fffff134 0 134 fffff000 0 0 0 0 1 f fffff134 0 0
0080a803 138 1000 0 0 1 deadbeef 0 1000 8 1 0 0 1 1 10 deadbeef 0 0
ffc10883 13c 2000 0 0 3 ffffff80 0 2000 fffffffc 1 0 2 1 1 11 ffffff80 0 0
0020d903 140 3000 0 0 0 beef 0 3000 2 1 0 1 0 1 12 beef 0 0
0000c983 144 3004 0 0 0 7f 0 3004 0 1 0 2 0 1 13 7f 0 0
0020a623 148 4000 cafef00d 0 2 0 0 4000 c 1 1 0 1 0 0 0 0 0
fe308fa3 14c 5000 a5 0 0 0 0 5000 ffffffff 1 1 2 1 0 0 0 0 0
00409323 150 6000 1234 0 4 0 0 6000 6 1 1 1 1 0 0 0 0 0
00208863 154 1 2 0 0 0 a 1 2 0 0 0 0 0 0 0 0 0
00209863 158 1 2 1 0 0 b 1 2 0 0 0 0 0 0 0 1 0
fe20cce3 15c ffffffff 1 1 0 0 c ffffffff 1 0 0 0 0 0 0 0 1 0
0020f463 160 1 2 0 0 0 f 1 2 0 0 0 0 0 0 0 0 0
100000ef 164 0 0 0 0 168 0 164 100 0 0 0 0 1 1 168 1 0
ffdff2ef 200 0 0 0 0 204 0 200 fffffffc 0 0 0 0 1 5 204 1 0
0000007f 204 11 22 0 0 0 0 11 22 0 0 0 0 0 0 0 0 1
023100b3 208 5 6 0 0 0 0 5 6 0 0 0 0 0 0 0 0 1
0020a863 20c 1 2 1 0 0 0 1 2 0 0 0 0 0 0 0 0 1
0020c623 210 7000 0 0 0 0 0 7000 c 0 0 0 0 0 0 0 0 1
80000f93 214 0 0 0 0 fffff800 0 0 fffff800 0 0 0 0 1 1f fffff800 0 0
